//--- src/mips_pkg.sv
package mips_pkg;

    localparam int data_width = 32;
    localparam int reg_addr_width = 5;
    localparam int reg_count = 32;

    typedef logic [data_width-1:0] word_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    // Primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_andi = 6'h0c;
    localparam logic [5:0] op_ori = 6'h0d;
    localparam logic [5:0] op_xori = 6'h0e;
    localparam logic [5:0] op_lui = 6'h0f;
    localparam logic [5:0] op_lw = 6'h23;
    localparam logic [5:0] op_sw = 6'h2b;

    // SPECIAL function field
    localparam logic [5:0] fn_sll = 6'h00;
    localparam logic [5:0] fn_srl = 6'h02;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or = 6'h25;
    localparam logic [5:0] fn_xor = 6'h26;
    localparam logic [5:0] fn_nor = 6'h27;
    localparam logic [5:0] fn_slt = 6'h2a;

    typedef enum logic [3:0] {
        alu_nop,
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_lui,
        alu_load,
        alu_store
    } alu_op_t;

    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            reg_addr_t rs;
            reg_addr_t rt;
            reg_addr_t rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0] opcode;
            reg_addr_t rs;
            reg_addr_t rt;
            logic [15:0] imm;
        } i;
    } instr_t;

endpackage

//--- src/stage_if.sv
interface issue_if;
    mips_pkg::alu_op_t alu_op;
    mips_pkg::word_t operand_a;
    mips_pkg::word_t operand_b;
    mips_pkg::word_t store_data;
    mips_pkg::reg_addr_t dest;
    logic write_enable;

    modport decode (
        output alu_op, operand_a, operand_b, store_data, dest, write_enable
    );

    modport execute (
        input alu_op, operand_a, operand_b, store_data, dest, write_enable
    );
endinterface

interface result_if;
    logic write_enable;
    mips_pkg::reg_addr_t dest;
    mips_pkg::word_t data;
    mips_pkg::alu_op_t alu_op;
    mips_pkg::word_t mem_addr;

    modport producer (output write_enable, dest, data, alu_op, mem_addr);

    modport consumer (input write_enable, dest, data, alu_op, mem_addr);

    // Bypass view for decode
    modport forward (input write_enable, dest, data);
endinterface

//--- src/fetch_unit.sv
module fetch_unit #(
    parameter mips_pkg::word_t reset_vector = '0
) (
    input  logic            clock,
    input  logic            reset,
    output mips_pkg::word_t rom_address,
    output logic            rom_chip_enable,
    output mips_pkg::word_t pc,
    output mips_pkg::word_t instruction,
    input  mips_pkg::word_t rom_data
);

    // Hold the vector for the first enabled cycle, then step one word
    always_ff @(posedge clock) begin
        if (reset) begin
            rom_address <= reset_vector;
            rom_chip_enable <= 1'b0;
        end else begin
            rom_chip_enable <= 1'b1;
            if (rom_chip_enable) begin
                rom_address <= rom_address + 32'd4;
            end
        end
    end

    // Fetch/decode register
    always_ff @(posedge clock) begin
        if (reset || !rom_chip_enable) begin
            instruction <= '0;
        end else begin
            instruction <= rom_data;
        end
        pc <= rom_address;
    end

endmodule

//--- src/regfile.sv
module regfile (
    input  logic                clock,
    input  logic                reset,
    input  logic                write_enable,
    input  mips_pkg::reg_addr_t write_address,
    input  mips_pkg::word_t     write_data,
    input  mips_pkg::reg_addr_t read_address_a,
    input  mips_pkg::reg_addr_t read_address_b,
    output mips_pkg::word_t     read_data_a,
    output mips_pkg::word_t     read_data_b
);

    mips_pkg::word_t regs [mips_pkg::reg_count];

    function automatic mips_pkg::word_t read_port(
        input mips_pkg::reg_addr_t addr,
        input mips_pkg::word_t     stored,
        input logic                we,
        input mips_pkg::reg_addr_t waddr,
        input mips_pkg::word_t     wdata
    );
        if (addr == '0) begin
            return '0;
        end
        // Write-through of the value retiring this cycle
        if (we && waddr == addr) begin
            return wdata;
        end
        return stored;
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < mips_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_address != '0) begin
            regs[write_address] <= write_data;
        end
    end

    assign read_data_a = read_port(read_address_a, regs[read_address_a],
                                   write_enable, write_address, write_data);
    assign read_data_b = read_port(read_address_b, regs[read_address_b],
                                   write_enable, write_address, write_data);

endmodule

//--- src/decode_stage.sv
module decode_stage (
    input  logic                clock,
    input  logic                reset,
    input  mips_pkg::word_t     instruction,
    output mips_pkg::reg_addr_t read_address_a,
    output mips_pkg::reg_addr_t read_address_b,
    input  mips_pkg::word_t     read_data_a,
    input  mips_pkg::word_t     read_data_b,
    result_if.forward           ex_result,
    result_if.forward           mem_result,
    issue_if.decode             issue
);

    mips_pkg::instr_t word;
    mips_pkg::alu_op_t alu_op;
    mips_pkg::reg_addr_t dest;
    logic write_enable;
    logic sign_extend;
    logic use_imm;
    logic is_shift;
    mips_pkg::word_t imm_value;
    mips_pkg::word_t value_a;
    mips_pkg::word_t value_b;

    // Youngest producer wins
    function automatic mips_pkg::word_t forward(
        input mips_pkg::reg_addr_t addr,
        input mips_pkg::word_t     rf_value,
        input logic                ex_we,
        input mips_pkg::reg_addr_t ex_dest,
        input mips_pkg::word_t     ex_data,
        input logic                mem_we,
        input mips_pkg::reg_addr_t mem_dest,
        input mips_pkg::word_t     mem_data
    );
        if (addr == '0) begin
            return '0;
        end
        if (ex_we && ex_dest == addr) begin
            return ex_data;
        end
        if (mem_we && mem_dest == addr) begin
            return mem_data;
        end
        return rf_value;
    endfunction

    assign word = instruction;
    assign read_address_a = word.r.rs;
    assign read_address_b = word.r.rt;

    always_comb begin
        alu_op = mips_pkg::alu_nop;
        dest = word.i.rt;
        write_enable = 1'b1;
        sign_extend = 1'b0;
        use_imm = 1'b1;
        case (word.i.opcode)
            mips_pkg::op_special: begin
                dest = word.r.rd;
                use_imm = 1'b0;
                case (word.r.funct)
                    mips_pkg::fn_addu: alu_op = mips_pkg::alu_add;
                    mips_pkg::fn_subu: alu_op = mips_pkg::alu_sub;
                    mips_pkg::fn_and: alu_op = mips_pkg::alu_and;
                    mips_pkg::fn_or: alu_op = mips_pkg::alu_or;
                    mips_pkg::fn_xor: alu_op = mips_pkg::alu_xor;
                    mips_pkg::fn_nor: alu_op = mips_pkg::alu_nor;
                    mips_pkg::fn_slt: alu_op = mips_pkg::alu_slt;
                    mips_pkg::fn_sll: alu_op = mips_pkg::alu_sll;
                    mips_pkg::fn_srl: alu_op = mips_pkg::alu_srl;
                    default: write_enable = 1'b0;
                endcase
            end
            mips_pkg::op_addiu: begin
                alu_op = mips_pkg::alu_add;
                sign_extend = 1'b1;
            end
            mips_pkg::op_andi: alu_op = mips_pkg::alu_and;
            mips_pkg::op_ori: alu_op = mips_pkg::alu_or;
            mips_pkg::op_xori: alu_op = mips_pkg::alu_xor;
            mips_pkg::op_lui: alu_op = mips_pkg::alu_lui;
            mips_pkg::op_lw: begin
                alu_op = mips_pkg::alu_load;
                sign_extend = 1'b1;
            end
            mips_pkg::op_sw: begin
                alu_op = mips_pkg::alu_store;
                sign_extend = 1'b1;
                write_enable = 1'b0;
            end
            default: write_enable = 1'b0;
        endcase
        // The all-zero word is a true NOP, not a shift of $0
        if (instruction == '0) begin
            alu_op = mips_pkg::alu_nop;
            write_enable = 1'b0;
        end
    end

    assign is_shift = (alu_op == mips_pkg::alu_sll) || (alu_op == mips_pkg::alu_srl);
    assign imm_value = sign_extend ? {{16{word.i.imm[15]}}, word.i.imm}
                                   : {16'b0, word.i.imm};

    assign value_a = forward(word.r.rs, read_data_a,
                             ex_result.write_enable, ex_result.dest, ex_result.data,
                             mem_result.write_enable, mem_result.dest, mem_result.data);
    assign value_b = forward(word.r.rt, read_data_b,
                             ex_result.write_enable, ex_result.dest, ex_result.data,
                             mem_result.write_enable, mem_result.dest, mem_result.data);

    // Decode/execute register
    always_ff @(posedge clock) begin
        if (reset) begin
            issue.alu_op <= mips_pkg::alu_nop;
            issue.write_enable <= 1'b0;
            issue.dest <= '0;
        end else begin
            issue.alu_op <= alu_op;
            issue.write_enable <= write_enable;
            issue.dest <= dest;
        end
        // Shifts take the amount in a and the shifted value in b
        issue.operand_a <= is_shift ? {27'b0, word.r.shamt} : value_a;
        issue.operand_b <= use_imm ? imm_value : value_b;
        issue.store_data <= value_b;
    end

endmodule

//--- src/execute_stage.sv
module execute_stage (
    issue_if.execute   issue,
    result_if.producer ex_result
);

    mips_pkg::word_t alu_result;

    always_comb begin
        case (issue.alu_op)
            mips_pkg::alu_add: alu_result = issue.operand_a + issue.operand_b;
            mips_pkg::alu_sub: alu_result = issue.operand_a - issue.operand_b;
            mips_pkg::alu_and: alu_result = issue.operand_a & issue.operand_b;
            mips_pkg::alu_or: alu_result = issue.operand_a | issue.operand_b;
            mips_pkg::alu_xor: alu_result = issue.operand_a ^ issue.operand_b;
            mips_pkg::alu_nor: alu_result = ~(issue.operand_a | issue.operand_b);
            mips_pkg::alu_slt: begin
                alu_result = {31'b0, $signed(issue.operand_a) < $signed(issue.operand_b)};
            end
            mips_pkg::alu_sll: alu_result = issue.operand_b << issue.operand_a[4:0];
            mips_pkg::alu_srl: alu_result = issue.operand_b >> issue.operand_a[4:0];
            mips_pkg::alu_lui: alu_result = {issue.operand_b[15:0], 16'b0};
            // NOP and loads carry no data out of this stage
            default: alu_result = '0;
        endcase
    end

    assign ex_result.write_enable = issue.write_enable;
    assign ex_result.dest = issue.dest;
    assign ex_result.alu_op = issue.alu_op;
    // Base plus offset, used only by loads and stores
    assign ex_result.mem_addr = issue.operand_a + issue.operand_b;
    // A store sends its data word along in place of a result
    assign ex_result.data = (issue.alu_op == mips_pkg::alu_store) ? issue.store_data
                                                                 : alu_result;

endmodule

//--- src/memory_stage.sv
module memory_stage (
    input  logic                clock,
    input  logic                reset,
    result_if.consumer          ex_result,
    output mips_pkg::word_t     ram_address,
    output mips_pkg::word_t     ram_data_out,
    output logic                ram_write_enable,
    output logic                ram_chip_enable,
    input  mips_pkg::word_t     ram_data_in,
    result_if.producer          mem_result,
    output logic                write_enable,
    output mips_pkg::reg_addr_t write_address,
    output mips_pkg::word_t     write_data
);

    logic stage_write_enable;
    mips_pkg::alu_op_t stage_op;
    mips_pkg::reg_addr_t stage_dest;
    mips_pkg::word_t stage_data;
    mips_pkg::word_t stage_addr;
    logic is_load;
    logic is_store;
    mips_pkg::word_t result_data;

    // Execute/memory register
    always_ff @(posedge clock) begin
        if (reset) begin
            stage_write_enable <= 1'b0;
            stage_op <= mips_pkg::alu_nop;
        end else begin
            stage_write_enable <= ex_result.write_enable;
            stage_op <= ex_result.alu_op;
        end
        stage_dest <= ex_result.dest;
        stage_data <= ex_result.data;
        stage_addr <= ex_result.mem_addr;
    end

    assign is_load = (stage_op == mips_pkg::alu_load);
    assign is_store = (stage_op == mips_pkg::alu_store);

    assign ram_address = stage_addr;
    assign ram_data_out = stage_data;
    assign ram_write_enable = is_store;
    assign ram_chip_enable = is_load || is_store;

    assign result_data = is_load ? ram_data_in : stage_data;

    assign mem_result.write_enable = stage_write_enable;
    assign mem_result.dest = stage_dest;
    assign mem_result.data = result_data;
    assign mem_result.alu_op = stage_op;
    assign mem_result.mem_addr = stage_addr;

    // Memory/write-back register
    always_ff @(posedge clock) begin
        if (reset) begin
            write_enable <= 1'b0;
        end else begin
            write_enable <= stage_write_enable;
        end
        write_address <= stage_dest;
        write_data <= result_data;
    end

endmodule

//--- src/mips_core.sv
module mips_core #(
    parameter mips_pkg::word_t reset_vector = '0
) (
    input  logic            clock,
    input  logic            reset,

    input  mips_pkg::word_t rom_data,
    output mips_pkg::word_t rom_address,
    output logic            rom_chip_enable,

    input  mips_pkg::word_t ram_data_in,
    output mips_pkg::word_t ram_address,
    output mips_pkg::word_t ram_data_out,
    output logic            ram_write_enable,
    output logic            ram_chip_enable
);

    mips_pkg::word_t instruction;
    mips_pkg::reg_addr_t read_address_a;
    mips_pkg::reg_addr_t read_address_b;
    mips_pkg::word_t read_data_a;
    mips_pkg::word_t read_data_b;
    logic wb_write_enable;
    mips_pkg::reg_addr_t wb_write_address;
    mips_pkg::word_t wb_write_data;

    issue_if issue ();
    result_if ex_result ();
    result_if mem_result ();

    fetch_unit #(
        .reset_vector(reset_vector)
    ) u_fetch (
        .clock(clock),
        .reset(reset),
        .rom_address(rom_address),
        .rom_chip_enable(rom_chip_enable),
        .pc(),
        .instruction(instruction),
        .rom_data(rom_data)
    );

    regfile u_regfile (
        .clock(clock),
        .reset(reset),
        .write_enable(wb_write_enable),
        .write_address(wb_write_address),
        .write_data(wb_write_data),
        .read_address_a(read_address_a),
        .read_address_b(read_address_b),
        .read_data_a(read_data_a),
        .read_data_b(read_data_b)
    );

    decode_stage u_decode (
        .clock(clock),
        .reset(reset),
        .instruction(instruction),
        .read_address_a(read_address_a),
        .read_address_b(read_address_b),
        .read_data_a(read_data_a),
        .read_data_b(read_data_b),
        .ex_result(ex_result),
        .mem_result(mem_result),
        .issue(issue)
    );

    execute_stage u_execute (
        .issue(issue),
        .ex_result(ex_result)
    );

    memory_stage u_memory (
        .clock(clock),
        .reset(reset),
        .ex_result(ex_result),
        .ram_address(ram_address),
        .ram_data_out(ram_data_out),
        .ram_write_enable(ram_write_enable),
        .ram_chip_enable(ram_chip_enable),
        .ram_data_in(ram_data_in),
        .mem_result(mem_result),
        .write_enable(wb_write_enable),
        .write_address(wb_write_address),
        .write_data(wb_write_data)
    );

endmodule

//--- verification/mips_core_sva.sv
module mips_core_sva (
    input logic            clock,
    input logic            reset,
    input mips_pkg::word_t rom_address,
    input logic            rom_chip_enable,
    input mips_pkg::word_t ram_address,
    input logic            ram_write_enable,
    input logic            ram_chip_enable
);

    write_needs_enable: assert property (@(posedge clock) ram_write_enable |-> ram_chip_enable)
        else $error("ram_write_enable high while ram_chip_enable is low");

    // First enabled cycle holds the vector, later ones step one word
    fetch_steps_by_word: assert property (@(posedge clock) disable iff (reset)
        rom_chip_enable && $past(rom_chip_enable) |-> rom_address == $past(rom_address) + 32'd4)
        else $error("rom_address did not advance by 4");

    ram_word_aligned: assert property (@(posedge clock) disable iff (reset)
        ram_chip_enable |-> ram_address[1:0] == 2'b00)
        else $error("ram_address not word-aligned during an access");

endmodule

bind mips_core mips_core_sva u_sva (
    .clock(clock),
    .reset(reset),
    .rom_address(rom_address),
    .rom_chip_enable(rom_chip_enable),
    .ram_address(ram_address),
    .ram_write_enable(ram_write_enable),
    .ram_chip_enable(ram_chip_enable)
);

//--- verification/mips_core_tb.sv
module mips_core_tb;

    localparam int clock_period = 100;
    localparam int reset_cycles = 8;
    localparam int random_seed = 2791;
    localparam int rom_words = 256;
    localparam int ram_words = 64;
    localparam int nop_tail = 8;
    localparam int hot_regs = 8;
    localparam int stop_address = rom_words * 4 + 16;
    localparam int run_limit = rom_words + 64;

    logic clock;
    logic reset;
    mips_pkg::word_t rom_data;
    mips_pkg::word_t rom_address;
    logic rom_chip_enable;
    mips_pkg::word_t ram_data_in;
    mips_pkg::word_t ram_address;
    mips_pkg::word_t ram_data_out;
    logic ram_write_enable;
    logic ram_chip_enable;

    mips_pkg::word_t rom [rom_words];
    mips_pkg::word_t ram [ram_words];
    mips_pkg::word_t model_ram [ram_words];
    mips_pkg::word_t model_regs [mips_pkg::reg_count];
    mips_pkg::word_t store_addr_q [$];
    mips_pkg::word_t store_data_q [$];
    mips_pkg::word_t load_addr_q [$];

    mips_core #(
        .reset_vector(32'h0)
    ) u_dut (
        .clock(clock),
        .reset(reset),
        .rom_data(rom_data),
        .rom_address(rom_address),
        .rom_chip_enable(rom_chip_enable),
        .ram_data_in(ram_data_in),
        .ram_address(ram_address),
        .ram_data_out(ram_data_out),
        .ram_write_enable(ram_write_enable),
        .ram_chip_enable(ram_chip_enable)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(clock_period / 2) clock = ~clock;
        end
    end

    task automatic stop_on_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_value(input string name, input mips_pkg::word_t expected,
                                 input mips_pkg::word_t actual);
        if (actual !== expected) begin
            $display("mismatch at time %0t: %s expected %h actual %h",
                     $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    // Small register set keeps dependencies dense
    function automatic mips_pkg::reg_addr_t pick_source(input mips_pkg::reg_addr_t load_dest);
        mips_pkg::reg_addr_t r;
        r = mips_pkg::reg_addr_t'($urandom % hot_regs);
        while (r != '0 && r == load_dest) begin
            r = mips_pkg::reg_addr_t'($urandom % hot_regs);
        end
        return r;
    endfunction

    function automatic logic [15:0] ram_offset();
        return 16'(($urandom % ram_words) * 4);
    endfunction

    function automatic logic [5:0] alu_funct(input int kind);
        case (kind)
            0: return mips_pkg::fn_addu;
            1: return mips_pkg::fn_subu;
            2: return mips_pkg::fn_and;
            3: return mips_pkg::fn_or;
            4: return mips_pkg::fn_xor;
            5: return mips_pkg::fn_nor;
            default: return mips_pkg::fn_slt;
        endcase
    endfunction

    function automatic logic [5:0] imm_opcode(input int kind);
        case (kind)
            9: return mips_pkg::op_addiu;
            10: return mips_pkg::op_andi;
            11: return mips_pkg::op_ori;
            12: return mips_pkg::op_xori;
            default: return mips_pkg::op_lui;
        endcase
    endfunction

    task automatic generate_program();
        mips_pkg::reg_addr_t load_dest;
        mips_pkg::reg_addr_t src_a;
        mips_pkg::reg_addr_t src_b;
        mips_pkg::reg_addr_t dest;
        logic [15:0] imm;
        int kind;
        load_dest = '0;
        for (int i = 0; i < rom_words; i++) begin
            kind = $urandom % 20;
            src_a = pick_source(load_dest);
            src_b = pick_source(load_dest);
            dest = mips_pkg::reg_addr_t'($urandom % hot_regs);
            imm = 16'($urandom);
            load_dest = '0;
            if (i >= rom_words - nop_tail || kind == 19) begin
                rom[i] = '0;
            end else if (kind < 7) begin
                rom[i] = {mips_pkg::op_special, src_a, src_b, dest, 5'd0, alu_funct(kind)};
            end else if (kind < 9) begin
                rom[i] = {mips_pkg::op_special, 5'd0, src_b, dest, imm[4:0],
                          (kind == 7) ? mips_pkg::fn_sll : mips_pkg::fn_srl};
            end else if (kind < 14) begin
                rom[i] = {imm_opcode(kind), src_a, dest, imm};
            end else if (kind < 16) begin
                rom[i] = {mips_pkg::op_lw, 5'd0, dest, ram_offset()};
                load_dest = dest;
            end else begin
                rom[i] = {mips_pkg::op_sw, 5'd0, src_b, ram_offset()};
            end
        end
    endtask

    // In-order reference execution of one instruction word
    task automatic execute_reference(input mips_pkg::word_t w);
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        mips_pkg::word_t sext;
        mips_pkg::word_t zext;
        mips_pkg::word_t result;
        mips_pkg::word_t addr;
        mips_pkg::reg_addr_t dest;
        logic writes;
        a = model_regs[w[25:21]];
        b = model_regs[w[20:16]];
        sext = {{16{w[15]}}, w[15:0]};
        zext = {16'b0, w[15:0]};
        addr = a + sext;
        result = '0;
        dest = w[20:16];
        writes = 1'b1;
        if (w == '0) begin
            writes = 1'b0;
        end else begin
            case (w[31:26])
                mips_pkg::op_special: begin
                    dest = w[15:11];
                    case (w[5:0])
                        mips_pkg::fn_addu: result = a + b;
                        mips_pkg::fn_subu: result = a - b;
                        mips_pkg::fn_and: result = a & b;
                        mips_pkg::fn_or: result = a | b;
                        mips_pkg::fn_xor: result = a ^ b;
                        mips_pkg::fn_nor: result = ~(a | b);
                        mips_pkg::fn_slt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        mips_pkg::fn_sll: result = b << w[10:6];
                        mips_pkg::fn_srl: result = b >> w[10:6];
                        default: writes = 1'b0;
                    endcase
                end
                mips_pkg::op_addiu: result = a + sext;
                mips_pkg::op_andi: result = a & zext;
                mips_pkg::op_ori: result = a | zext;
                mips_pkg::op_xori: result = a ^ zext;
                mips_pkg::op_lui: result = {w[15:0], 16'b0};
                mips_pkg::op_lw: begin
                    load_addr_q.push_back(addr);
                    result = model_ram[addr[7:2]];
                end
                mips_pkg::op_sw: begin
                    writes = 1'b0;
                    store_addr_q.push_back(addr);
                    store_data_q.push_back(b);
                    model_ram[addr[7:2]] = b;
                end
                default: writes = 1'b0;
            endcase
        end
        if (writes && dest != '0) begin
            model_regs[dest] = result;
        end
    endtask

    // Checks the RAM port, updates the RAM model and answers both memories
    task automatic service_memories();
        mips_pkg::word_t expected_addr;
        mips_pkg::word_t expected_data;
        rom_data = '0;
        if (rom_chip_enable && rom_address < rom_words * 4) begin
            rom_data = rom[rom_address[9:2]];
        end
        ram_data_in = '0;
        if (ram_write_enable) begin
            compare_value("ram_chip_enable", 32'd1, ram_chip_enable);
            if (store_addr_q.size() == 0) begin
                $display("store seen at time %0t but the program has no store left", $time);
                stop_on_failure();
            end else begin
                expected_addr = store_addr_q.pop_front();
                expected_data = store_data_q.pop_front();
                compare_value("ram_address", expected_addr, ram_address);
                compare_value("ram_data_out", expected_data, ram_data_out);
                ram[ram_address[7:2]] = ram_data_out;
            end
        end else if (ram_chip_enable) begin
            if (load_addr_q.size() == 0) begin
                $display("load seen at time %0t but the program has no load left", $time);
                stop_on_failure();
            end else begin
                expected_addr = load_addr_q.pop_front();
                compare_value("ram_address", expected_addr, ram_address);
                ram_data_in = ram[ram_address[7:2]];
            end
        end
    endtask

    initial begin
        int cycles;
        mips_pkg::word_t expected_address;
        reset = 1'b1;
        rom_data = '0;
        ram_data_in = '0;
        void'($urandom(random_seed));
        for (int i = 0; i < ram_words; i++) begin
            ram[i] = $urandom;
            model_ram[i] = ram[i];
        end
        for (int i = 0; i < mips_pkg::reg_count; i++) begin
            model_regs[i] = '0;
        end
        generate_program();
        for (int i = 0; i < rom_words; i++) begin
            execute_reference(rom[i]);
        end

        for (int i = 0; i < reset_cycles; i++) begin
            @(negedge clock);
            compare_value("rom_chip_enable", 32'd0, rom_chip_enable);
            compare_value("ram_chip_enable", 32'd0, ram_chip_enable);
            compare_value("ram_write_enable", 32'd0, ram_write_enable);
            service_memories();
        end
        reset = 1'b0;

        // Run past the program end and until every predicted access has shown
        expected_address = '0;
        cycles = 0;
        while ((store_addr_q.size() != 0 || load_addr_q.size() != 0
                || expected_address != stop_address) && cycles < run_limit) begin
            @(negedge clock);
            compare_value("rom_chip_enable", 32'd1, rom_chip_enable);
            compare_value("rom_address", expected_address, rom_address);
            service_memories();
            expected_address = expected_address + 32'd4;
            cycles++;
        end
        if (store_addr_q.size() != 0 || load_addr_q.size() != 0) begin
            $display("timeout: the DUT never issued every predicted load and store");
            stop_on_failure();
        end else begin
            for (int i = 0; i < ram_words; i++) begin
                compare_value($sformatf("ram[%0d]", i), model_ram[i], ram[i]);
            end
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

//--- vlog.f
src/mips_pkg.sv
src/stage_if.sv
src/fetch_unit.sv
src/regfile.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/mips_core.sv
verification/mips_core_sva.sv
verification/mips_core_tb.sv
